// File: controlUnit.f
source/controlPkg.sv
source/instructionDecoder.sv
source/controlSequencer.sv
source/controlWordTable.sv
source/controlUnit.sv
tests/clockGen.sv
tests/controlUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f controlUnit.f --top-module controlUnitTb -o controlUnitSim
./obj_dir/controlUnitSim | tee sim.log

if grep -qx "all tests passed" sim.log; then
	echo "simulation result: pass"
else
	echo "simulation result: fail"
	exit 1
fi

// File: source/controlPkg.sv
package controlPkg;

	localparam int opcodeWidth = 6;
	localparam int functWidth = 6;

	localparam logic [opcodeWidth-1:0] opcodeRType = 6'h00; // Funct selects the operation
	localparam logic [opcodeWidth-1:0] opcodeJ = 6'h02;
	localparam logic [opcodeWidth-1:0] opcodeBeq = 6'h04;
	localparam logic [opcodeWidth-1:0] opcodeBne = 6'h05;
	localparam logic [opcodeWidth-1:0] opcodeAddi = 6'h08;
	localparam logic [opcodeWidth-1:0] opcodeAddiu = 6'h09;
	localparam logic [opcodeWidth-1:0] opcodeSlti = 6'h0a;
	localparam logic [opcodeWidth-1:0] opcodeAndi = 6'h0c;
	localparam logic [opcodeWidth-1:0] opcodeXori = 6'h0e;
	localparam logic [opcodeWidth-1:0] opcodeLw = 6'h23;
	localparam logic [opcodeWidth-1:0] opcodeSw = 6'h2b;

	localparam logic [functWidth-1:0] functSll = 6'h00;
	localparam logic [functWidth-1:0] functSrl = 6'h02;
	localparam logic [functWidth-1:0] functSra = 6'h03;
	localparam logic [functWidth-1:0] functJr = 6'h08;
	localparam logic [functWidth-1:0] functAdd = 6'h20;
	localparam logic [functWidth-1:0] functAddu = 6'h21;
	localparam logic [functWidth-1:0] functSub = 6'h22;
	localparam logic [functWidth-1:0] functSubu = 6'h23;
	localparam logic [functWidth-1:0] functAnd = 6'h24;
	localparam logic [functWidth-1:0] functXor = 6'h26;
	localparam logic [functWidth-1:0] functSlt = 6'h2a;

	typedef enum logic [6:0] {
		fetch, fetchWait, irLoad, decode,
		rLoad, addCheck, subCheck, aluExec, aluWrite, sltWrite,
		shiftLoad, shiftWrite, jumpReg,
		immLoad, immCheck, immExec, immWrite, sltiWrite,
		memAddr, loadRead, loadWait, loadWrite, storeWrite,
		branchEq, branchNe, jump,
		overflowTrap, opcodeTrap
	} stateT;

	typedef enum logic [4:0] {
		clsAdd, clsSub, clsAddu, clsSubu, clsAnd, clsXor, clsSlt,
		clsSll, clsSrl, clsSra, clsJr,
		clsAddi, clsAddiu, clsAndi, clsSlti, clsXori,
		clsLw, clsSw, clsBeq, clsBne, clsJ,
		clsIllegal
	} instrClassT;

	typedef enum logic [2:0] {aluPass, aluAdd, aluSub, aluAnd, aluXor} aluOpT;

	typedef enum logic [1:0] {pcAluResult, pcAluOut, pcJumpTarget, pcException} pcSourceT;

	typedef enum logic [1:0] {srcRegB, srcFour, srcImmediate, srcBranchOffset} aluSrcBT;

	typedef enum logic [1:0] {wbAluOut, wbMemData, wbLessThan, wbShift} memToRegT;

	// Shift register is loaded first, then shifted by shamt
	typedef enum logic [2:0] {
		shiftIdle, shiftLoadReg, shiftLeft, shiftRightLogic, shiftRightArith
	} shiftOpT;

	typedef struct packed {
		pcSourceT pcSource;
		logic pcWrite;
		logic pcWriteCond;
		logic branchNotEqual; // Inverts the zero test of pcWriteCond
		logic aluSrcA; // 0 selects PC, 1 register A
		aluSrcBT aluSrcB;
		aluOpT aluOp;
		logic aluOutLoad;
		logic saveOverflow;
		logic regALoad;
		logic regBLoad;
		logic regWrite;
		logic regDestRd; // Low writes rt
		memToRegT memToReg;
		logic irWrite;
		logic iorD;
		logic memWrite;
		logic mdrLoad;
		shiftOpT shiftOp;
		logic epcWrite;
	} controlWordT;

	localparam controlWordT idleControl = '{
		pcSource: pcAluResult,
		pcWrite: 1'b0,
		pcWriteCond: 1'b0,
		branchNotEqual: 1'b0,
		aluSrcA: 1'b0,
		aluSrcB: srcRegB,
		aluOp: aluPass,
		aluOutLoad: 1'b0,
		saveOverflow: 1'b0,
		regALoad: 1'b0,
		regBLoad: 1'b0,
		regWrite: 1'b0,
		regDestRd: 1'b0,
		memToReg: wbAluOut,
		irWrite: 1'b0,
		iorD: 1'b0,
		memWrite: 1'b0,
		mdrLoad: 1'b0,
		shiftOp: shiftIdle,
		epcWrite: 1'b0
	};

endpackage

// File: source/controlSequencer.sv
`timescale 1ns/1ns

module controlSequencer (
	input logic clock,
	input logic reset,
	input controlPkg::instrClassT instrClass,
	input logic overflow,
	output controlPkg::stateT state
);
	import controlPkg::*;

	stateT nextState;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = fetch; // Terminal states return to fetch
		case (state)
			fetch: nextState = fetchWait;
			fetchWait: nextState = irLoad; // Memory read latency
			irLoad: nextState = decode;
			decode: begin
				case (instrClass)
					clsAdd, clsSub, clsAddu, clsSubu, clsAnd, clsXor, clsSlt,
					clsSll, clsSrl, clsSra, clsJr: nextState = rLoad;
					clsAddi, clsAddiu, clsAndi, clsSlti, clsXori: nextState = immLoad;
					clsLw, clsSw: nextState = memAddr;
					clsBeq: nextState = branchEq;
					clsBne: nextState = branchNe;
					clsJ: nextState = jump;
					default: nextState = opcodeTrap;
				endcase
			end
			rLoad: begin
				case (instrClass)
					clsAdd: nextState = addCheck;
					clsSub: nextState = subCheck;
					clsAddu, clsSubu, clsAnd, clsXor: nextState = aluExec;
					clsSlt: nextState = sltWrite;
					clsSll, clsSrl, clsSra: nextState = shiftLoad;
					clsJr: nextState = jumpReg;
					default: nextState = opcodeTrap;
				endcase
			end
			addCheck, subCheck: nextState = overflow ? overflowTrap : aluWrite;
			aluExec: nextState = aluWrite;
			shiftLoad: nextState = shiftWrite;
			immLoad: begin
				case (instrClass)
					clsAddi: nextState = immCheck;
					clsAddiu, clsAndi, clsXori: nextState = immExec;
					clsSlti: nextState = sltiWrite;
					default: nextState = opcodeTrap;
				endcase
			end
			immCheck: nextState = overflow ? overflowTrap : immWrite;
			immExec: nextState = immWrite;
			memAddr: begin
				case (instrClass)
					clsLw: nextState = loadRead;
					clsSw: nextState = storeWrite;
					default: nextState = opcodeTrap;
				endcase
			end
			loadRead: nextState = loadWait;
			loadWait: nextState = loadWrite;
			default: nextState = fetch;
		endcase
	end

	// A trap lasts one cycle and restarts at the exception vector
	trapReturnsToFetch: assert property (@(posedge clock) disable iff (reset)
		(state == overflowTrap || state == opcodeTrap) |=> state == fetch)
	else $error("trap state not followed by fetch");

endmodule

// File: source/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
	input logic clock,
	input logic reset,
	input logic [controlPkg::opcodeWidth-1:0] opcode,
	input logic [controlPkg::functWidth-1:0] funct,
	input logic overflow,
	output controlPkg::stateT state,
	output controlPkg::controlWordT control
);
	import controlPkg::*;

	instrClassT instrClass;

	instructionDecoder decoder (
		.opcode(opcode),
		.funct(funct),
		.instrClass(instrClass)
	);

	controlSequencer sequencer (
		.clock(clock),
		.reset(reset),
		.instrClass(instrClass),
		.overflow(overflow),
		.state(state)
	);

	controlWordTable wordTable (
		.state(state),
		.instrClass(instrClass), // ALU and shift function per class
		.control(control)
	);

endmodule

// File: source/controlWordTable.sv
`timescale 1ns/1ns

module controlWordTable (
	input controlPkg::stateT state,
	input controlPkg::instrClassT instrClass,
	output controlPkg::controlWordT control
);
	import controlPkg::*;

	always_comb begin
		control = idleControl;
		case (state)
			fetch: begin
				control.pcWrite = 1'b1; // PC + 4
				control.aluSrcB = srcFour;
				control.aluOp = aluAdd;
			end
			irLoad: control.irWrite = 1'b1;
			decode: begin
				control.regALoad = 1'b1;
				control.regBLoad = 1'b1;
				control.aluSrcB = srcBranchOffset; // Branch target ahead of time
				control.aluOp = aluAdd;
				control.aluOutLoad = 1'b1;
			end
			rLoad: begin
				control.regALoad = 1'b1;
				control.regBLoad = 1'b1;
			end
			immLoad: control.regALoad = 1'b1;
			addCheck, subCheck, aluExec, immCheck, immExec, memAddr: begin
				control.aluSrcA = 1'b1;
				control.aluOutLoad = 1'b1;
				control.saveOverflow = (state == addCheck || state == subCheck || state == immCheck);
				control.aluSrcB = (state == addCheck || state == subCheck || state == aluExec) ?
					srcRegB : srcImmediate;
				case (instrClass)
					clsSub, clsSubu: control.aluOp = aluSub;
					clsAnd, clsAndi: control.aluOp = aluAnd;
					clsXor, clsXori: control.aluOp = aluXor;
					default: control.aluOp = aluAdd;
				endcase
			end
			aluWrite, immWrite: begin
				control.regWrite = 1'b1;
				control.regDestRd = (state == aluWrite);
			end
			sltWrite, sltiWrite: begin
				control.aluSrcA = 1'b1;
				control.aluSrcB = (state == sltWrite) ? srcRegB : srcImmediate;
				control.aluOp = aluSub; // Less-than flag comes from the subtraction
				control.regWrite = 1'b1;
				control.regDestRd = (state == sltWrite);
				control.memToReg = wbLessThan;
			end
			shiftLoad: control.shiftOp = shiftLoadReg;
			shiftWrite: begin
				case (instrClass)
					clsSrl: control.shiftOp = shiftRightLogic;
					clsSra: control.shiftOp = shiftRightArith;
					default: control.shiftOp = shiftLeft;
				endcase
				control.regWrite = 1'b1;
				control.regDestRd = 1'b1;
				control.memToReg = wbShift;
			end
			jumpReg: begin
				control.aluSrcA = 1'b1;
				control.aluOp = aluPass; // Register A straight to PC
				control.pcWrite = 1'b1;
			end
			loadRead: control.iorD = 1'b1;
			loadWait: begin
				control.iorD = 1'b1;
				control.mdrLoad = 1'b1;
			end
			loadWrite: begin
				control.regWrite = 1'b1;
				control.memToReg = wbMemData;
			end
			storeWrite: begin
				control.iorD = 1'b1;
				control.memWrite = 1'b1;
			end
			branchEq, branchNe: begin
				control.aluSrcA = 1'b1;
				control.aluOp = aluSub;
				control.pcSource = pcAluOut;
				control.pcWriteCond = 1'b1;
				control.branchNotEqual = (state == branchNe);
			end
			jump: begin
				control.pcSource = pcJumpTarget;
				control.pcWrite = 1'b1;
			end
			overflowTrap, opcodeTrap: begin
				control.aluSrcB = srcFour;
				control.aluOp = aluSub; // EPC gets the faulting PC
				control.epcWrite = 1'b1;
				control.pcSource = pcException;
				control.pcWrite = 1'b1;
			end
			default: control = idleControl;
		endcase

		assert (!(control.memWrite && control.regWrite))
		else $error("memWrite and regWrite together in state %s", state.name());
	end

endmodule

// File: source/instructionDecoder.sv
`timescale 1ns/1ns

module instructionDecoder (
	input logic [controlPkg::opcodeWidth-1:0] opcode,
	input logic [controlPkg::functWidth-1:0] funct,
	output controlPkg::instrClassT instrClass
);
	import controlPkg::*;

	always_comb begin
		instrClass = clsIllegal;
		case (opcode)
			opcodeRType: begin
				case (funct)
					functAdd: instrClass = clsAdd;
					functSub: instrClass = clsSub;
					functAddu: instrClass = clsAddu;
					functSubu: instrClass = clsSubu;
					functAnd: instrClass = clsAnd;
					functXor: instrClass = clsXor;
					functSlt: instrClass = clsSlt;
					functSll: instrClass = clsSll; // Also covers the all-zero nop
					functSrl: instrClass = clsSrl;
					functSra: instrClass = clsSra;
					functJr: instrClass = clsJr;
					default: instrClass = clsIllegal;
				endcase
			end
			opcodeAddi: instrClass = clsAddi;
			opcodeAddiu: instrClass = clsAddiu;
			opcodeAndi: instrClass = clsAndi;
			opcodeSlti: instrClass = clsSlti;
			opcodeXori: instrClass = clsXori;
			opcodeLw: instrClass = clsLw;
			opcodeSw: instrClass = clsSw;
			opcodeBeq: instrClass = clsBeq;
			opcodeBne: instrClass = clsBne;
			opcodeJ: instrClass = clsJ;
			default: instrClass = clsIllegal; // Unknown opcodes raise the trap
		endcase
	end

endmodule

// File: tests/clockGen.sv
`timescale 1ns/1ns

module clockGen (
	output logic clock,
	output logic reset
);
	localparam int halfPeriod = 2; // 4 ns period
	localparam int resetCycles = 10;

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0; // Released on a falling edge
	end

	always #halfPeriod clock = ~clock;

endmodule

// File: tests/controlUnitTb.sv
`timescale 1ns/1ns

module controlUnitTb;
	import controlPkg::*;

	localparam int instrCount = 300;
	localparam int timeoutCycles = instrCount * 8 + 100; // Longest instruction is lw
	localparam int entryCount = 26;

	typedef struct packed {
		logic [opcodeWidth-1:0] opcode;
		logic [functWidth-1:0] funct;
		instrClassT cls;
	} instrEntryT;

	// Control fields that carry meaning masked by their enables
	typedef struct packed {
		logic regWrite;
		logic regDestRd;
		memToRegT memToReg;
		logic memWrite;
		logic storeAddr;
		logic pcWrite;
		logic pcIncrement;
		logic irWrite;
		logic pcWriteCond;
		logic branchNotEqual;
		logic epcWrite;
		logic trapVector;
	} checkedT;

	logic clock;
	logic reset;
	logic [opcodeWidth-1:0] opcode;
	logic [functWidth-1:0] funct;
	logic overflow;
	stateT state;
	controlWordT control;

	stateT expState;
	stateT expected [$];
	logic checking;
	string testName;
	int cycleCount;
	instrEntryT entries [entryCount];

	clockGen clocks (.clock(clock), .reset(reset));

	controlUnit uut (.clock(clock), .reset(reset), .opcode(opcode), .funct(funct),
		.overflow(overflow), .state(state), .control(control));

	function automatic string stateText(input stateT value);
		return value.name();
	endfunction

	function automatic checkedT observed(input controlWordT c);
		checkedT o;
		o.regWrite = c.regWrite;
		o.regDestRd = c.regWrite & c.regDestRd;
		o.memToReg = c.regWrite ? c.memToReg : wbAluOut;
		o.memWrite = c.memWrite;
		o.storeAddr = c.memWrite & c.iorD;
		o.pcWrite = c.pcWrite;
		o.pcIncrement = c.pcWrite & (c.aluOp == aluAdd) & (c.aluSrcB == srcFour) &
			(c.pcSource == pcAluResult);
		o.irWrite = c.irWrite;
		o.pcWriteCond = c.pcWriteCond;
		o.branchNotEqual = c.pcWriteCond & c.branchNotEqual;
		o.epcWrite = c.epcWrite;
		o.trapVector = c.epcWrite & (c.pcSource == pcException);
		return o;
	endfunction

	function automatic checkedT expectedFor(input stateT s);
		checkedT e;
		e = '0;
		case (s)
			fetch: begin
				e.pcWrite = 1'b1;
				e.pcIncrement = 1'b1; // PC + 4
			end
			jump, jumpReg: e.pcWrite = 1'b1;
			irLoad: e.irWrite = 1'b1;
			aluWrite, immWrite: begin
				e.regWrite = 1'b1;
				e.regDestRd = (s == aluWrite);
			end
			sltWrite, sltiWrite: begin
				e.regWrite = 1'b1;
				e.regDestRd = (s == sltWrite);
				e.memToReg = wbLessThan;
			end
			shiftWrite: begin
				e.regWrite = 1'b1;
				e.regDestRd = 1'b1;
				e.memToReg = wbShift;
			end
			loadWrite: begin
				e.regWrite = 1'b1; // Writes rt
				e.memToReg = wbMemData;
			end
			storeWrite: begin
				e.memWrite = 1'b1;
				e.storeAddr = 1'b1;
			end
			branchEq, branchNe: begin
				e.pcWriteCond = 1'b1;
				e.branchNotEqual = (s == branchNe);
			end
			overflowTrap, opcodeTrap: begin
				e.pcWrite = 1'b1;
				e.epcWrite = 1'b1;
				e.trapVector = 1'b1;
			end
			default: e = '0;
		endcase
		return e;
	endfunction

	// One entry per cycle from fetch to fetch
	function automatic void buildSequence(input instrClassT cls, input logic ovf);
		expected = {fetch, fetchWait, irLoad, decode};
		case (cls)
			clsJ: expected.push_back(jump);
			clsBeq: expected.push_back(branchEq);
			clsBne: expected.push_back(branchNe);
			clsJr: expected = {expected, rLoad, jumpReg};
			clsSlt: expected = {expected, rLoad, sltWrite};
			clsSw: expected = {expected, memAddr, storeWrite};
			clsSlti: expected = {expected, immLoad, sltiWrite};
			clsAddu, clsSubu, clsAnd, clsXor: expected = {expected, rLoad, aluExec, aluWrite};
			clsAdd: expected = {expected, rLoad, addCheck, ovf ? overflowTrap : aluWrite};
			clsSub: expected = {expected, rLoad, subCheck, ovf ? overflowTrap : aluWrite};
			clsSll, clsSrl, clsSra: expected = {expected, rLoad, shiftLoad, shiftWrite};
			clsAddiu, clsAndi, clsXori: expected = {expected, immLoad, immExec, immWrite};
			clsAddi: expected = {expected, immLoad, immCheck, ovf ? overflowTrap : immWrite};
			clsLw: expected = {expected, memAddr, loadRead, loadWait, loadWrite};
			default: expected.push_back(opcodeTrap);
		endcase
	endfunction

	task automatic failRun();
		$display("tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic reportMismatch(input string check, input string exp, input string act);
		$display("[FAIL] %s %s: expected %s actual %s", testName, check, exp, act);
		failRun();
	endtask

	sequenceMatch: assert property (@(posedge clock) disable iff (!checking) state == expState)
	else reportMismatch("state", stateText(expState), stateText($sampled(state)));

	controlMatch: assert property (@(posedge clock) disable iff (reset)
		observed(control) == expectedFor(expState))
	else reportMismatch("control", $sformatf("%p", expectedFor(expState)),
		$sformatf("%p", observed($sampled(control))));

	resetQuiet: assert property (@(posedge clock)
		reset |-> !(control.regWrite || control.memWrite || control.epcWrite))
	else reportMismatch("reset writes", "none", $sformatf("%p", $sampled(control)));

	resetRelease: assert property (@(posedge clock)
		$fell(reset) |-> state == fetch && control.pcWrite)
	else reportMismatch("reset release", "fetch pcWrite 1", $sformatf("%s pcWrite %b",
		stateText($sampled(state)), $sampled(control.pcWrite)));

	initial begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout: no end of test after %0d cycles", cycleCount);
		failRun();
	end

	initial begin
		instrEntryT entry;
		void'($urandom(60));
		opcode = '0;
		funct = '0;
		overflow = 1'b0;
		checking = 1'b0;
		expState = fetch;
		testName = "reset";
		entries = '{
			'{opcodeRType, functAdd, clsAdd}, '{opcodeRType, functSub, clsSub},
			'{opcodeRType, functAddu, clsAddu}, '{opcodeRType, functSubu, clsSubu},
			'{opcodeRType, functAnd, clsAnd}, '{opcodeRType, functXor, clsXor},
			'{opcodeRType, functSlt, clsSlt}, '{opcodeRType, functSll, clsSll},
			'{opcodeRType, functSrl, clsSrl}, '{opcodeRType, functSra, clsSra},
			'{opcodeRType, functJr, clsJr}, '{opcodeAddi, 6'h00, clsAddi},
			'{opcodeAddiu, 6'h00, clsAddiu}, '{opcodeAndi, 6'h00, clsAndi},
			'{opcodeSlti, 6'h00, clsSlti}, '{opcodeXori, 6'h00, clsXori},
			'{opcodeLw, 6'h00, clsLw}, '{opcodeSw, 6'h00, clsSw},
			'{opcodeBeq, 6'h00, clsBeq}, '{opcodeBne, 6'h00, clsBne},
			'{opcodeJ, 6'h00, clsJ}, '{opcodeRType, 6'h04, clsIllegal},
			'{opcodeRType, 6'h0d, clsIllegal}, '{6'h0f, 6'h00, clsIllegal},
			'{6'h03, 6'h00, clsIllegal}, '{6'h24, 6'h00, clsIllegal}
		}; // sllv, break, lui, jal and lbu are illegal here
		@(negedge reset);
		checking = 1'b1;
		for (int i = 0; i < instrCount; i++) begin
			entry = entries[$urandom_range(entryCount - 1)];
			opcode = entry.opcode;
			// Funct is noise outside R-type
			funct = (entry.opcode == opcodeRType) ? entry.funct : 6'($urandom);
			overflow = 1'($urandom);
			testName = entry.cls.name();
			buildSequence(entry.cls, overflow);
			foreach (expected[k]) begin
				expState = expected[k];
				@(negedge clock);
			end
		end
		expState = fetch; // Last instruction must return to fetch
		@(negedge clock);
		$display("all tests passed");
		$finish;
	end

endmodule
